//--- common/raycast_pkg.sv
package raycast_pkg;

  // Screen coordinate, wide enough for both counters
  typedef logic [9:0] pos_t;

  // Colour word, blue pair then green pair then red pair, MSB first
  typedef logic [5:0] rgb_t;

  // Index into one 64-entry texel plane
  typedef logic [5:0] texel_idx_t;

  // Wall slice number sent to the flash, wall id minus one, side, texu
  typedef logic [8:0] slice_addr_t;

  // Wall id, where 0 means there is no wall on this column
  typedef logic [1:0] wall_id_t;

  // Half height of the wall span in pixels
  typedef logic [8:0] half_size_t;

  // Texture step, unsigned with 6 fraction bits
  typedef logic [11:0] tex_step_t;

  // Visible and total pixels per line, and sync pulse bounds
  localparam pos_t H_VIEW       = 10'd640;
  localparam pos_t H_TOTAL      = 10'd800;
  localparam pos_t H_SYNC_START = 10'd656;
  localparam pos_t H_SYNC_END   = 10'd752;

  // Visible and total lines per frame, and sync pulse bounds
  localparam pos_t V_VIEW       = 10'd480;
  localparam pos_t V_TOTAL      = 10'd525;
  localparam pos_t V_SYNC_START = 10'd490;
  localparam pos_t V_SYNC_END   = 10'd492;

  // Middle of the rotated column, where floor turns into sky
  localparam pos_t HALF_VIEW = 10'd320;

  // Quad output fast read, with its preamble made of command, address and dummy clocks
  localparam logic [7:0] TEX_CMD           = 8'h6B;
  localparam pos_t       TSPI_CMD_LEN      = 10'd8;
  localparam pos_t       TSPI_ADDR_LEN     = 10'd24;
  localparam pos_t       TSPI_DUMMY_LEN    = 10'd8;
  localparam pos_t       TSPI_PREAMBLE_LEN = TSPI_CMD_LEN + TSPI_ADDR_LEN + TSPI_DUMMY_LEN;
  localparam int         TEXEL_COUNT       = 64;
  // One byte per texel arrives as two nibbles
  localparam pos_t       TSPI_READ_LEN     = 10'd128;
  localparam pos_t       TSPI_STREAM_LEN   = TSPI_PREAMBLE_LEN + TSPI_READ_LEN;
  // The stream starts so that the read data begins right as the line blanks
  localparam pos_t       TSPI_HPOS_START   = H_VIEW - TSPI_PREAMBLE_LEN;

  // APB register window
  localparam int                  APB_AW     = 4;
  localparam logic [APB_AW-1:0]   REG_COLORS = 4'h0;
  localparam logic [APB_AW-1:0]   REG_WALL   = 4'h4;
  localparam logic [APB_AW-1:0]   REG_SIZE   = 4'h8;
  localparam logic [APB_AW-1:0]   REG_STEP   = 4'hC;

  // Values the registers take out of reset
  localparam rgb_t      SKY_RST  = 6'h15;
  localparam rgb_t      FLOOR_RST = 6'h2A;
  localparam tex_step_t STEP_RST = 12'h040;

endpackage

//--- hdl/vga_timing.sv
`timescale 1ns/100ps

module vga_timing import raycast_pkg::*; (
  input  logic clk,
  input  logic i_rst_n,
  output pos_t o_hpos,
  output pos_t o_vpos,
  output logic o_hsync_n,
  output logic o_vsync_n,
  output logic o_hblank,
  output logic o_vblank,
  output logic o_visible,
  output logic o_hmax,
  output logic o_frame_end
);

  logic vmax;

  // Last pixel of a line and last line of a frame
  assign o_hmax = (o_hpos == H_TOTAL - 10'd1);
  assign vmax   = (o_vpos == V_TOTAL - 10'd1);

  // Both counters wrap, vpos only steps at the end of each line
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_hpos <= '0;
      o_vpos <= '0;
    end else begin
      o_hpos <= o_hmax ? '0 : o_hpos + 10'd1;
      if (o_hmax) begin
        o_vpos <= vmax ? '0 : o_vpos + 10'd1;
      end
    end
  end

  // Sync pulses are active low inside their half-open windows
  assign o_hsync_n = ~((o_hpos >= H_SYNC_START) && (o_hpos < H_SYNC_END));
  assign o_vsync_n = ~((o_vpos >= V_SYNC_START) && (o_vpos < V_SYNC_END));

  assign o_hblank  = (o_hpos >= H_VIEW);
  assign o_vblank  = (o_vpos >= V_VIEW);
  assign o_visible = ~o_hblank & ~o_vblank;

  // Last pixel of the last visible line, when new settings may be taken up
  assign o_frame_end = o_hmax && (o_vpos == V_VIEW - 10'd1);

endmodule

//--- hdl/apb_view_regs.sv
`timescale 1ns/100ps

module apb_view_regs import raycast_pkg::*; (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_psel,
  input  logic             i_penable,
  input  logic             i_pwrite,
  // One bit above the register window, so accesses past it can be flagged
  input  logic [APB_AW:0]  i_paddr,
  input  logic [31:0]      i_pwdata,
  output logic [31:0]      o_prdata,
  output logic             o_pready,
  output logic             o_pslverr,
  input  logic             i_frame_end,
  output rgb_t             o_sky,
  output rgb_t             o_floor,
  output wall_id_t         o_wall_id,
  output logic             o_side,
  output texel_idx_t       o_texu,
  output half_size_t       o_half_size,
  output tex_step_t        o_tex_step
);

  rgb_t        pend_sky;
  rgb_t        pend_floor;
  wall_id_t    pend_wall_id;
  logic        pend_side;
  texel_idx_t  pend_texu;
  half_size_t  pend_half_size;
  tex_step_t   pend_tex_step;
  logic        addr_hit;
  logic [31:0] rd_word;
  logic        access;

  // Every transfer finishes in its access phase
  assign o_pready = 1'b1;
  assign access   = i_psel & i_penable;

  // Address decode and read mux over the pending set
  always_comb begin
    addr_hit = ~i_paddr[APB_AW];
    rd_word  = '0;
    case (i_paddr[APB_AW-1:0])
      REG_COLORS: rd_word = {20'd0, pend_floor, pend_sky};
      REG_WALL:   rd_word = {23'd0, pend_wall_id, pend_side, pend_texu};
      REG_SIZE:   rd_word = {23'd0, pend_half_size};
      REG_STEP:   rd_word = {20'd0, pend_tex_step};
      default:    addr_hit = 1'b0;
    endcase
  end

  // Unmapped addresses read back as zero
  assign o_prdata  = addr_hit ? rd_word : '0;
  assign o_pslverr = access & ~addr_hit;

  // Software writes land in the pending set only
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      pend_sky       <= SKY_RST;
      pend_floor     <= FLOOR_RST;
      pend_wall_id   <= '0;
      pend_side      <= 1'b0;
      pend_texu      <= '0;
      pend_half_size <= '0;
      pend_tex_step  <= STEP_RST;
    end else if (access && i_pwrite && addr_hit) begin
      case (i_paddr[APB_AW-1:0])
        REG_COLORS: begin
          pend_floor <= i_pwdata[11:6];
          pend_sky   <= i_pwdata[5:0];
        end
        REG_WALL: begin
          pend_wall_id <= i_pwdata[8:7];
          pend_side    <= i_pwdata[6];
          pend_texu    <= i_pwdata[5:0];
        end
        REG_SIZE: pend_half_size <= i_pwdata[8:0];
        REG_STEP: pend_tex_step  <= i_pwdata[11:0];
        default: ;
      endcase
    end
  end

  // The renderer sees new values only from the start of the next frame
  // so a frame is never drawn with a mix of old and new settings
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_sky       <= SKY_RST;
      o_floor     <= FLOOR_RST;
      o_wall_id   <= '0;
      o_side      <= 1'b0;
      o_texu      <= '0;
      o_half_size <= '0;
      o_tex_step  <= STEP_RST;
    end else if (i_frame_end) begin
      o_sky       <= pend_sky;
      o_floor     <= pend_floor;
      o_wall_id   <= pend_wall_id;
      o_side      <= pend_side;
      o_texu      <= pend_texu;
      o_half_size <= pend_half_size;
      o_tex_step  <= pend_tex_step;
    end
  end

endmodule

//--- texture/tex_qspi_fetch.sv
`timescale 1ns/100ps

module tex_qspi_fetch import raycast_pkg::*; (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  pos_t                   i_hpos,
  input  wall_id_t               i_wall_id,
  input  logic                   i_side,
  input  texel_idx_t             i_texu,
  input  logic [3:0]             i_tex_in,
  output logic                   o_tex_csb,
  output logic                   o_tex_sclk,
  output logic                   o_tex_out0,
  output logic [TEXEL_COUNT-1:0] o_tex_r0,
  output logic [TEXEL_COUNT-1:0] o_tex_r1,
  output logic [TEXEL_COUNT-1:0] o_tex_g0,
  output logic [TEXEL_COUNT-1:0] o_tex_g1,
  output logic [TEXEL_COUNT-1:0] o_tex_b0,
  output logic [TEXEL_COUNT-1:0] o_tex_b1
);

  pos_t        tspi_state;
  wall_id_t    wall_base;
  slice_addr_t slice_addr;
  logic [23:0] flash_addr;
  logic        in_cmd;
  logic        in_addr;
  logic        in_data;

  // Wall ids start at 1 in the registers but at 0 in the flash image
  assign wall_base  = i_wall_id - 2'd1;
  assign slice_addr = {wall_base, i_side, i_texu};

  // Each slice is 64 bytes, one byte per texel
  assign flash_addr = {9'd0, slice_addr, 6'd0};

  // The sequencer position follows hpos and wraps modulo 1024
  assign tspi_state = i_hpos - TSPI_HPOS_START;

  assign in_cmd  = (tspi_state < TSPI_CMD_LEN);
  assign in_addr = ~in_cmd && (tspi_state < TSPI_CMD_LEN + TSPI_ADDR_LEN);
  assign in_data = (tspi_state >= TSPI_PREAMBLE_LEN) && (tspi_state < TSPI_STREAM_LEN);

  // Chip select stays low for the whole command and read stream
  assign o_tex_csb = ~(tspi_state < TSPI_STREAM_LEN);

  // The flash clock is the inverted system clock, so io0 set up on the rising
  // clk edge is already stable when sclk rises half a cycle later
  assign o_tex_sclk = ~clk;

  // Command bit 7-s in states 0 to 7, address bit 31-s in states 8 to 31
  // Both indices are simply the inverted low state bits
  always_comb begin
    if (in_cmd) begin
      o_tex_out0 = TEX_CMD[~tspi_state[2:0]];
    end else if (in_addr) begin
      o_tex_out0 = flash_addr[~tspi_state[4:0]];
    end else begin
      o_tex_out0 = 1'b0;
    end
  end

  // Nibbles alternate between colour LSB planes on even states and MSB planes
  // on odd states. io0 carries no colour data
  // Each plane fills from its top, so after 64 shifts the first texel sits at 0
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_tex_r0 <= '0;
      o_tex_r1 <= '0;
      o_tex_g0 <= '0;
      o_tex_g1 <= '0;
      o_tex_b0 <= '0;
      o_tex_b1 <= '0;
    end else if (in_data) begin
      if (!tspi_state[0]) begin
        o_tex_r0 <= {i_tex_in[1], o_tex_r0[TEXEL_COUNT-1:1]};
        o_tex_g0 <= {i_tex_in[2], o_tex_g0[TEXEL_COUNT-1:1]};
        o_tex_b0 <= {i_tex_in[3], o_tex_b0[TEXEL_COUNT-1:1]};
      end else begin
        o_tex_r1 <= {i_tex_in[1], o_tex_r1[TEXEL_COUNT-1:1]};
        o_tex_g1 <= {i_tex_in[2], o_tex_g1[TEXEL_COUNT-1:1]};
        o_tex_b1 <= {i_tex_in[3], o_tex_b1[TEXEL_COUNT-1:1]};
      end
    end
  end

endmodule

//--- render/column_shader.sv
`timescale 1ns/100ps

module column_shader import raycast_pkg::*; (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  pos_t                   i_hpos,
  input  logic                   i_visible,
  input  logic                   i_hmax,
  input  wall_id_t               i_wall_id,
  input  half_size_t             i_half_size,
  input  tex_step_t              i_tex_step,
  input  rgb_t                   i_sky,
  input  rgb_t                   i_floor,
  input  logic [TEXEL_COUNT-1:0] i_tex_r0,
  input  logic [TEXEL_COUNT-1:0] i_tex_r1,
  input  logic [TEXEL_COUNT-1:0] i_tex_g0,
  input  logic [TEXEL_COUNT-1:0] i_tex_g1,
  input  logic [TEXEL_COUNT-1:0] i_tex_b0,
  input  logic [TEXEL_COUNT-1:0] i_tex_b1,
  output rgb_t                   o_rgb
);

  logic [10:0] hpos_ext;
  logic [10:0] half_ext;
  logic [10:0] mid_ext;
  logic        above_lo;
  logic        below_hi;
  logic        in_wall;
  tex_step_t   tex_acc;
  texel_idx_t  texv;
  rgb_t        wall_rgb;
  rgb_t        bg_rgb;

  // One extra bit keeps the span ends from wrapping when the half size
  // is larger than the middle of the column
  assign hpos_ext = {1'b0, i_hpos};
  assign half_ext = {2'b00, i_half_size};
  assign mid_ext  = {1'b0, HALF_VIEW};

  // Span is [mid - half, mid + half), the low bound moved to the other side
  assign above_lo = (hpos_ext + half_ext) >= mid_ext;
  assign below_hi = hpos_ext < (mid_ext + half_ext);
  assign in_wall  = (i_wall_id != '0) && above_lo && below_hi;

  // Texture v runs from 0 at the first wall pixel, one step per pixel
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      tex_acc <= '0;
    end else if (i_hmax || !in_wall) begin
      tex_acc <= '0;
    end else begin
      tex_acc <= tex_acc + i_tex_step;
    end
  end

  // Integer part of the accumulator picks the texel
  assign texv = tex_acc[11:6];

  // Texel colour rebuilt from its six bit planes
  assign wall_rgb = {
    i_tex_b1[texv], i_tex_b0[texv],
    i_tex_g1[texv], i_tex_g0[texv],
    i_tex_r1[texv], i_tex_r0[texv]
  };

  // Rotated screen, so the low half of the column is the floor
  assign bg_rgb = (i_hpos < HALF_VIEW) ? i_floor : i_sky;

  // Blanking forces black, then the wall covers the background
  always_comb begin
    if (!i_visible) begin
      o_rgb = '0;
    end else if (in_wall) begin
      o_rgb = wall_rgb;
    end else begin
      o_rgb = bg_rgb;
    end
  end

endmodule

//--- hdl/raycast_top.sv
`timescale 1ns/100ps

module raycast_top import raycast_pkg::*; (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_psel,
  input  logic            i_penable,
  input  logic            i_pwrite,
  input  logic [APB_AW:0] i_paddr,
  input  logic [31:0]     i_pwdata,
  output logic [31:0]     o_prdata,
  output logic            o_pready,
  output logic            o_pslverr,
  output logic            o_tex_csb,
  output logic            o_tex_sclk,
  output logic            o_tex_out0,
  input  logic [3:0]      i_tex_in,
  output logic            o_hsync_n,
  output logic            o_vsync_n,
  output logic            o_hblank,
  output logic            o_vblank,
  output rgb_t            o_rgb,
  output pos_t            o_hpos,
  output pos_t            o_vpos
);

  logic             visible;
  logic             hmax;
  logic             frame_end;
  rgb_t             sky;
  rgb_t             floor_rgb;
  wall_id_t         wall_id;
  logic             side;
  texel_idx_t       texu;
  half_size_t       half_size;
  tex_step_t        tex_step;
  logic [TEXEL_COUNT-1:0] tex_r0, tex_r1, tex_g0, tex_g1, tex_b0, tex_b1;

  // Screen counters and sync
  vga_timing u_vga_timing (
    .clk(clk), .i_rst_n(i_rst_n),
    .o_hpos(o_hpos), .o_vpos(o_vpos),
    .o_hsync_n(o_hsync_n), .o_vsync_n(o_vsync_n),
    .o_hblank(o_hblank), .o_vblank(o_vblank),
    .o_visible(visible), .o_hmax(hmax), .o_frame_end(frame_end)
  );

  // View settings written over APB
  apb_view_regs u_regs (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
    .i_frame_end(frame_end),
    .o_sky(sky), .o_floor(floor_rgb),
    .o_wall_id(wall_id), .o_side(side), .o_texu(texu),
    .o_half_size(half_size), .o_tex_step(tex_step)
  );

  // Slice fetch for the next line during horizontal blanking
  tex_qspi_fetch u_fetch (
    .clk(clk), .i_rst_n(i_rst_n), .i_hpos(o_hpos),
    .i_wall_id(wall_id), .i_side(side), .i_texu(texu), .i_tex_in(i_tex_in),
    .o_tex_csb(o_tex_csb), .o_tex_sclk(o_tex_sclk), .o_tex_out0(o_tex_out0),
    .o_tex_r0(tex_r0), .o_tex_r1(tex_r1), .o_tex_g0(tex_g0),
    .o_tex_g1(tex_g1), .o_tex_b0(tex_b0), .o_tex_b1(tex_b1)
  );

  // Pixel colour for the current column position
  column_shader u_shader (
    .clk(clk), .i_rst_n(i_rst_n), .i_hpos(o_hpos),
    .i_visible(visible), .i_hmax(hmax), .i_wall_id(wall_id),
    .i_half_size(half_size), .i_tex_step(tex_step),
    .i_sky(sky), .i_floor(floor_rgb),
    .i_tex_r0(tex_r0), .i_tex_r1(tex_r1), .i_tex_g0(tex_g0),
    .i_tex_g1(tex_g1), .i_tex_b0(tex_b0), .i_tex_b1(tex_b1),
    .o_rgb(o_rgb)
  );

endmodule

//--- bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Failed checks so far
int err_count = 0;

// Closes the run once the failure has been described
task automatic stop_on_error();
  err_count++;
  $display("Finished with errors");
  $fatal(1, "Simulation stopped at the first error");
endtask

// A wait loop ran out of cycles
task automatic report_timeout(input string what);
  $display("Timeout: gave up waiting for %s", what);
  stop_on_error();
endtask

// Pixel colours
task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
  if (got !== exp) begin
    $display("mismatch time %0t signal %s got %h expected %h", $time, name, got, exp);
    stop_on_error();
  end
endtask

// Screen counters
task automatic check_pos(input string name, input pos_t got, input pos_t exp);
  if (got !== exp) begin
    $display("mismatch time %0t signal %s got %0d expected %0d", $time, name, got, exp);
    stop_on_error();
  end
endtask

// Single-bit strobes, syncs and flags
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("mismatch time %0t signal %s got %b expected %b", $time, name, got, exp);
    stop_on_error();
  end
endtask

// APB data words
task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("mismatch time %0t signal %s got %h expected %h", $time, name, got, exp);
    stop_on_error();
  end
endtask

`endif

//--- bench/tb_raycast.sv
`timescale 1ns/100ps

module tb_raycast import raycast_pkg::*; ();

  // Longest wait is one full frame plus some margin
  localparam int FRAME_CYCLES = 800 * 525;
  localparam int ENTRY_COUNT  = 5;

  // One table row: raw APB writes, the line to check and the masked read-back values
  typedef struct packed {
    logic [31:0] colors_wr;
    logic [31:0] wall_wr;
    logic [31:0] size_wr;
    logic [31:0] step_wr;
    logic [9:0]  line;
    logic [11:0] colors_exp;
    logic [8:0]  wall_exp;
    logic [8:0]  size_exp;
    logic [11:0] step_exp;
  } entry_t;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [APB_AW:0] paddr;
  logic [31:0]     pwdata;
  logic [31:0]     prdata;
  logic            pready;
  logic            pslverr;
  logic            tex_csb;
  logic            tex_sclk;
  logic            tex_out0;
  logic [3:0]      tex_in = 4'h0;
  logic            hsync_n;
  logic            vsync_n;
  logic            hblank;
  logic            vblank;
  rgb_t            rgb;
  pos_t            hpos;
  pos_t            vpos;

  // Flash image, 512 slices of 64 texel bytes, colour in bits 5:0
  logic [7:0]  rom [0:32767];
  entry_t      tbl [0:ENTRY_COUNT-1];
  int          flash_state;
  logic [23:0] flash_addr;
  logic [7:0]  texel;

  `include "tb_checks.svh"

  raycast_top u_dut (
    .clk(clk), .i_rst_n(rst_n),
    .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
    .i_paddr(paddr), .i_pwdata(pwdata),
    .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
    .o_tex_csb(tex_csb), .o_tex_sclk(tex_sclk), .o_tex_out0(tex_out0), .i_tex_in(tex_in),
    .o_hsync_n(hsync_n), .o_vsync_n(vsync_n), .o_hblank(hblank), .o_vblank(vblank),
    .o_rgb(rgb), .o_hpos(hpos), .o_vpos(vpos)
  );

  always #10 clk = ~clk;

  // Flash model, which takes io0 and drives nibbles on the rising sclk edge
  // i.e. the falling clk edge, one state per cycle since chip select fell
  always @(negedge clk) begin
    if (tex_csb) begin
      flash_state = 0;
      tex_in = 4'h0;
    end else begin
      // Address arrives MSB first after the 8 command bits
      if (flash_state >= 8 && flash_state < 32) begin
        flash_addr = {flash_addr[22:0], tex_out0};
      end
      if (flash_state >= 40 && flash_state < 168) begin
        texel = rom[flash_addr[14:0] + (flash_state - 40) / 2];
        // Even states carry the low bit of each colour pair, odd states the high bit
        if (flash_state % 2 == 0) begin
          tex_in = {texel[4], texel[2], texel[0], 1'b0};
        end else begin
          tex_in = {texel[5], texel[3], texel[1], 1'b0};
        end
      end else begin
        tex_in = 4'h0;
      end
      flash_state++;
    end
  end

  // Reference pixel from the register values of one table row
  function automatic rgb_t expected_pixel(input entry_t e, input int line, input int p);
    int          half;
    int          lo;
    int          k;
    int          acc_full;
    logic [14:0] byte_addr;
    half = e.size_exp;
    lo   = 320 - half;
    if (line >= 480 || p >= 640) begin
      return 6'h00;
    end
    if (e.wall_exp[8:7] != 2'd0 && p >= lo && p < 320 + half) begin
      // Accumulator counts from zero at the first wall pixel on the line
      k = (lo > 0) ? p - lo : p;
      acc_full = k * int'(e.step_exp);
      byte_addr = {e.wall_exp[8:7] - 2'd1, e.wall_exp[6:0], acc_full[11:6]};
      return rom[byte_addr][5:0];
    end
    return (p < 320) ? e.colors_exp[11:6] : e.colors_exp[5:0];
  endfunction

  // Reference io0 level at hpos p, command then slice byte address
  function automatic logic expected_io0(input entry_t e, input int p);
    logic [23:0] addr;
    addr = {9'd0, e.wall_exp[8:7] - 2'd1, e.wall_exp[6:0], 6'd0};
    if (p >= 600 && p < 608) begin
      return TEX_CMD[607 - p];
    end
    if (p >= 608 && p < 632) begin
      return addr[631 - p];
    end
    return 1'b0;
  endfunction

  // Called on a falling edge, returns on the falling edge at the target position
  task automatic wait_for_pos(input int line, input int col);
    int n;
    n = 0;
    while (!(vpos == line && hpos == col)) begin
      if (n > FRAME_CYCLES) begin
        report_timeout($sformatf("screen position line %0d hpos %0d", line, col));
      end
      @(negedge clk);
      n++;
    end
  endtask

  // One APB transfer, inputs change on the falling edge and outputs are
  // sampled mid-way through the low half of the access phase
  task automatic apb_access(input logic wr, input logic [APB_AW:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int n;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #5;
    n = 0;
    while (pready !== 1'b1) begin
      if (n > 16) begin
        report_timeout("o_pready in the APB access phase");
      end
      @(negedge clk);
      #5;
      n++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_and_read_back(input logic [APB_AW:0] addr, input logic [31:0] wdata,
                                     input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, wdata, rdata, err);
    check_bit("o_pslverr on write", err, 1'b0);
    apb_access(1'b0, addr, 32'h0, rdata, err);
    check_bit("o_pslverr on read", err, 1'b0);
    check_word($sformatf("o_prdata at 0x%h", addr), rdata, exp);
  endtask

  // Full frame of counters, syncs, blanking and chip select
  task automatic check_frame_timing();
    int v;
    int h;
    wait_for_pos(0, 0);
    for (v = 0; v < 525; v++) begin
      for (h = 0; h < 800; h++) begin
        check_pos("o_hpos", hpos, h);
        check_pos("o_vpos", vpos, v);
        check_bit("o_hsync_n", hsync_n, !(h >= 656 && h < 752));
        check_bit("o_vsync_n", vsync_n, !(v >= 490 && v < 492));
        check_bit("o_hblank", hblank, h >= 640);
        check_bit("o_vblank", vblank, v >= 480);
        check_bit("o_tex_csb", tex_csb, !(h >= 600 && h < 768));
        if (h >= 640 || v >= 480) begin
          check_rgb("o_rgb in blanking", rgb, 6'h00);
        end
        @(negedge clk);
      end
    end
  endtask

  // Every pixel and io0 bit of one line against a table row
  task automatic check_line(input entry_t e, input int line);
    int p;
    wait_for_pos(line, 0);
    for (p = 0; p < 800; p++) begin
      check_rgb($sformatf("o_rgb line %0d hpos %0d", line, p), rgb, expected_pixel(e, line, p));
      check_bit($sformatf("o_tex_out0 hpos %0d", p), tex_out0, expected_io0(e, p));
      @(negedge clk);
    end
  endtask

  // Flash clock must be the inverse of clk, so it is sampled in both phases
  // Called on a falling edge, the high phase is sampled 5 ns after the rising edge
  task automatic sclk_inversion_test(input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      check_bit("o_tex_sclk with clk low", tex_sclk, 1'b1);
      #15;
      check_bit("o_tex_sclk with clk high", tex_sclk, 1'b0);
      @(negedge clk);
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          rnd;
    int          i;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rnd = $urandom(32'h265f_cfb6);
    for (i = 0; i < 32768; i++) begin
      rnd = $urandom;
      rom[i] = rnd[7:0];
    end

    // Row 0 holds the reset state and is never written
    tbl[0] = {32'h0, 32'h0, 32'h0, 32'h0, 10'd0, 12'hA95, 9'h000, 9'h000, 12'h040};
    // New colours, no wall
    tbl[1] = {32'hDEAD_F3C7, 32'h0000_FE00, 32'h1234_5064, 32'hFFFF_F080,
              10'd5, 12'h3C7, 9'h000, 9'h064, 12'h080};
    // Centre span with one texel per pixel, wrapping the slice
    tbl[2] = {32'h0000_0A3C, 32'h8000_0085, 32'hFFFF_FE64, 32'h0BAD_0040,
              10'd100, 12'hA3C, 9'h085, 9'h064, 12'h040};
    // Span taller than the screen with a fractional step, checked on line 0
    tbl[3] = {32'h5A5A_5555, 32'h0000_316A, 32'h0000_01F0, 32'h7777_7015,
              10'd0, 12'h555, 9'h16A, 9'h1F0, 12'h015};
    // Narrow span with a large step
    tbl[4] = {32'h0000_0FC0, 32'hFFFF_FFBF, 32'h0000_0205, 32'h0000_0ABC,
              10'd300, 12'hFC0, 9'h1BF, 9'h005, 12'hABC};

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_pos("o_hpos after reset", hpos, 10'd0);
    check_pos("o_vpos after reset", vpos, 10'd0);
    check_bit("o_tex_csb after reset", tex_csb, 1'b1);
    check_bit("o_pslverr after reset", pslverr, 1'b0);

    sclk_inversion_test(8);

    // Unmapped address flags an error, reads zero and changes nothing
    apb_access(1'b1, 5'h10, 32'hFFFF_FFFF, rdata, err);
    check_bit("o_pslverr on unmapped write", err, 1'b1);
    apb_access(1'b0, 5'h10, 32'h0, rdata, err);
    check_bit("o_pslverr on unmapped read", err, 1'b1);
    check_word("o_prdata on unmapped read", rdata, 32'h0);
    apb_access(1'b0, REG_COLORS, 32'h0, rdata, err);
    check_word("o_prdata colours after unmapped write", rdata, {20'd0, tbl[0].colors_exp});

    check_frame_timing();

    // Each row must not show before the frame end, then must show after it
    for (i = 1; i < ENTRY_COUNT; i++) begin
      write_and_read_back(REG_COLORS, tbl[i].colors_wr, {20'd0, tbl[i].colors_exp});
      write_and_read_back(REG_WALL, tbl[i].wall_wr, {23'd0, tbl[i].wall_exp});
      write_and_read_back(REG_SIZE, tbl[i].size_wr, {23'd0, tbl[i].size_exp});
      write_and_read_back(REG_STEP, tbl[i].step_wr, {20'd0, tbl[i].step_exp});
      check_line(tbl[i-1], 479);
      check_line(tbl[i], tbl[i].line);
    end

    if (err_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

//--- Bender.yml
package:
  name: raycast_display

sources:
  - common/raycast_pkg.sv
  - hdl/vga_timing.sv
  - hdl/apb_view_regs.sv
  - texture/tex_qspi_fetch.sv
  - render/column_shader.sv
  - hdl/raycast_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_raycast.sv

//--- tb.f
+incdir+bench
common/raycast_pkg.sv
hdl/vga_timing.sv
hdl/apb_view_regs.sv
texture/tex_qspi_fetch.sv
render/column_shader.sv
hdl/raycast_top.sv
bench/tb_raycast.sv
